// File: sim.f
+incdir+design
design/cache_pkg.sv
design/sync_ram.sv
design/cache_tag_mem.sv
design/cache_data_mem.sv
design/cache_lru.sv
design/l1_cache.sv
tests/l1_cache_assert.sv
tests/l1_cache_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS := --binary --timing --assert -j 0
TOP := l1_cache_tb
FILELIST := sim.f
BUILD_DIR := obj_dir
SIM_ARGS := +verilator+error+limit+100
PASS_MSG := all tests passed

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tests/l1_cache_tb.sv
`include "cache_settings.svh"

module l1_cache_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// directed phases and 1000 random cycles come to about 1100 cycles
	localparam int CYCLE_LIMIT = 3000;

	logic clk;
	logic rst_i;
	logic [31:0] address_i;
	logic access_i;
	logic cache_hit_o;
	cache_pkg::way_t hit_way_o;
	cache_pkg::line_t data_o;
	logic fill_i;
	logic [31:0] fill_address_i;
	cache_pkg::line_t fill_data_i;
	logic invalidate_i;
	cache_pkg::set_t invalidate_set_i;
	cache_pkg::way_t invalidate_way_i;

	int cycle_count = 0;
	logic [31:0] recent_fills [$];
	cache_pkg::tag_t next_tag;

	l1_cache DUT (
		.clk(clk),
		.rst_i(rst_i),
		.address_i(address_i),
		.access_i(access_i),
		.cache_hit_o(cache_hit_o),
		.hit_way_o(hit_way_o),
		.data_o(data_o),
		.fill_i(fill_i),
		.fill_address_i(fill_address_i),
		.fill_data_i(fill_data_i),
		.invalidate_i(invalidate_i),
		.invalidate_set_i(invalidate_set_i),
		.invalidate_way_i(invalidate_way_i)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] build_address(cache_pkg::tag_t tag, cache_pkg::set_t set_idx);
		return {tag, set_idx, {`CACHE_OFFSET_BITS{1'b0}}};
	endfunction

	function automatic cache_pkg::line_t random_line();
		return {$urandom, $urandom};
	endfunction

	task automatic abort_run(input string reason);
		$display("tests failed");
		$fatal(1, "%s", reason);
	endtask

	// every strobe is held for exactly one clock
	task automatic drive_cycle(
		input logic acc,
		input logic [31:0] addr,
		input logic fil,
		input logic [31:0] faddr,
		input cache_pkg::line_t fdata,
		input logic inv,
		input cache_pkg::set_t iset,
		input cache_pkg::way_t iway
	);
		@(posedge clk);
		access_i <= acc;
		address_i <= addr;
		fill_i <= fil;
		fill_address_i <= faddr;
		fill_data_i <= fdata;
		invalidate_i <= inv;
		invalidate_set_i <= iset;
		invalidate_way_i <= iway;
	endtask

	task automatic idle_cycle();
		drive_cycle(1'b0, '0, 1'b0, '0, '0, 1'b0, '0, '0);
	endtask

	task automatic access_cycle(input logic [31:0] addr);
		drive_cycle(1'b1, addr, 1'b0, '0, '0, 1'b0, '0, '0);
	endtask

	task automatic fill_cycle(input logic [31:0] faddr);
		drive_cycle(1'b0, '0, 1'b1, faddr, random_line(), 1'b0, '0, '0);
	endtask

	task automatic invalidate_cycle(input cache_pkg::set_t iset, input cache_pkg::way_t iway);
		drive_cycle(1'b0, '0, 1'b0, '0, '0, 1'b1, iset, iway);
	endtask

	// watchdog and assertion monitor
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
			abort_run("timeout, the cycle limit was reached before the stimulus finished");
		else if (DUT.u_check.error_count != 0)
			abort_run("an assertion on the cache outputs failed");
	end

	initial
	begin
		int kind;
		logic acc;
		logic fil;
		logic inv;
		logic [31:0] addr;
		logic [31:0] faddr;
		cache_pkg::set_t set_idx;
		void'($urandom(81981));
		clk = 1'b0;
		rst_i = 1'b1;
		// a lookup is held during reset and must not report a hit
		access_i = 1'b1;
		address_i = build_address(21'h00010, 5'd3);
		fill_i = 1'b0;
		fill_address_i = '0;
		fill_data_i = '0;
		invalidate_i = 1'b0;
		invalidate_set_i = '0;
		invalidate_way_i = '0;
		next_tag = 21'h01000;
		repeat (3) @(posedge clk);
		rst_i <= 1'b0;
		access_i <= 1'b0;

		// nothing is valid yet, every lookup misses
		for (int i = 0; i < 4; i++)
			access_cycle(build_address(cache_pkg::tag_t'(i), 5'd3));

		// fill then hit, and a miss on another tag of the same set
		fill_cycle(build_address(21'h00100, 5'd3));
		access_cycle(build_address(21'h00100, 5'd3));
		access_cycle(build_address(21'h00101, 5'd3));

		// five tags into one set with hits in between steer the pseudo-LRU
		fill_cycle(build_address(21'h00200, 5'd5));
		fill_cycle(build_address(21'h00201, 5'd5));
		access_cycle(build_address(21'h00200, 5'd5));
		idle_cycle();
		fill_cycle(build_address(21'h00202, 5'd5));
		access_cycle(build_address(21'h00201, 5'd5));
		idle_cycle();
		fill_cycle(build_address(21'h00203, 5'd5));
		access_cycle(build_address(21'h00200, 5'd5));
		idle_cycle();
		fill_cycle(build_address(21'h00204, 5'd5));
		for (int i = 0; i < 5; i++)
			access_cycle(build_address(cache_pkg::tag_t'(21'h00200 + i), 5'd5));

		// invalidate one way, the rest of the set keeps hitting
		invalidate_cycle(5'd5, 2'd1);
		for (int i = 0; i < 5; i++)
			access_cycle(build_address(cache_pkg::tag_t'(21'h00200 + i), 5'd5));

		// fill and invalidate together, the fill has priority
		fill_cycle(build_address(21'h00300, 5'd7));
		drive_cycle(1'b0, '0, 1'b1, build_address(21'h00301, 5'd7), random_line(),
			1'b1, 5'd7, 2'd0);
		access_cycle(build_address(21'h00300, 5'd7));
		access_cycle(build_address(21'h00301, 5'd7));

		// lookups in the same cycle as a fill of that set see the old contents
		fill_cycle(build_address(21'h00400, 5'd9));
		idle_cycle();
		drive_cycle(1'b1, build_address(21'h00401, 5'd9), 1'b1, build_address(21'h00401, 5'd9),
			random_line(), 1'b0, '0, '0);
		drive_cycle(1'b1, build_address(21'h00400, 5'd9), 1'b1, build_address(21'h00402, 5'd9),
			random_line(), 1'b0, '0, '0);
		access_cycle(build_address(21'h00401, 5'd9));
		access_cycle(build_address(21'h00402, 5'd9));

		// random mix over four sets; fill tags are never reused
		for (int n = 0; n < 1000; n++)
		begin
			kind = $urandom_range(0, 9);
			set_idx = cache_pkg::set_t'(8 + $urandom_range(0, 3));
			acc = kind < 7;
			fil = kind >= 4 && kind < 8;
			inv = kind >= 7;
			if (recent_fills.size() > 0 && $urandom_range(0, 3) != 0)
				addr = recent_fills[$urandom_range(0, recent_fills.size() - 1)];
			else
				addr = build_address(cache_pkg::tag_t'(21'h1f0000 + $urandom_range(0, 7)), set_idx);
			faddr = build_address(next_tag, set_idx);
			drive_cycle(acc, addr, fil, faddr, random_line(), inv, set_idx,
				cache_pkg::way_t'($urandom_range(0, 3)));
			if (fil)
			begin
				recent_fills.push_back(faddr);
				next_tag++;
				if (recent_fills.size() > 16)
					void'(recent_fills.pop_front());
			end
		end

		repeat (4) idle_cycle();
		// assertions of the last rising edge have reported by the falling edge
		@(negedge clk);
		if (DUT.u_check.error_count == 0)
		begin
			$display("all tests passed");
			$finish;
		end
		else
		begin
			abort_run("an assertion failed near the end of the run");
		end
	end

endmodule

// File: tests/l1_cache_assert.sv
`include "cache_settings.svh"

module l1_cache_assert (
	input logic clk,
	input logic rst_i,
	input logic [31:0] address_i,
	input logic access_i,
	input logic cache_hit_i,
	input cache_pkg::way_t hit_way_i,
	input cache_pkg::line_t data_i,
	input logic fill_i,
	input logic [31:0] fill_address_i,
	input cache_pkg::line_t fill_data_i,
	input logic invalidate_i,
	input cache_pkg::set_t invalidate_set_i,
	input cache_pkg::way_t invalidate_way_i,
	input cache_pkg::way_t fill_way_i,
	input logic [3:0] way_hit_i
);

	timeunit 1ns;
	timeprecision 1ps;

	// shadow copy of the cache contents
	logic [3:0] valid_s [`CACHE_NUM_SETS];
	cache_pkg::tag_t tag_s [`CACHE_NUM_SETS][4];
	cache_pkg::line_t line_s [`CACHE_NUM_SETS][4];
	cache_pkg::lru_t lru_s [`CACHE_NUM_SETS];

	cache_pkg::set_t req_set;
	cache_pkg::tag_t req_tag;
	cache_pkg::set_t fill_set;
	cache_pkg::tag_t fill_tag;
	logic [3:0] req_match;
	cache_pkg::way_t req_way;
	cache_pkg::way_t victim;

	// expected lookup result, one cycle after the request
	logic exp_hit_q;
	cache_pkg::way_t exp_way_q;
	cache_pkg::set_t exp_set_q;
	cache_pkg::line_t exp_data_q;
	logic [3:0] exp_match_q;
	logic started_q = 1'b0;

	int error_count = 0;

	// the touched way becomes most recent, so its path bits point to the other side
	function automatic cache_pkg::lru_t mark_recent(cache_pkg::lru_t bits, cache_pkg::way_t way);
		cache_pkg::lru_t result;
		result = bits;
		result[0] = ~way[1];
		if (way[1])
			result[2] = ~way[0];
		else
			result[1] = ~way[0];
		return result;
	endfunction

	function automatic cache_pkg::way_t victim_of(cache_pkg::lru_t bits);
		if (!bits[0])
			return bits[1] ? 2'd1 : 2'd0;
		else
			return bits[2] ? 2'd3 : 2'd2;
	endfunction

	// tag is address bits 31 to 11, set index is bits 10 to 6
	assign req_set = address_i[10:6];
	assign req_tag = address_i[31:11];
	assign fill_set = fill_address_i[10:6];
	assign fill_tag = fill_address_i[31:11];
	assign victim = victim_of(lru_s[fill_set]);

	always_comb
	begin
		req_way = 2'd3;
		for (int w = 3; w >= 0; w--)
		begin
			req_match[w] = valid_s[req_set][w] && tag_s[req_set][w] == req_tag;
			if (req_match[w])
				req_way = cache_pkg::way_t'(w);
		end
	end

	always @(posedge clk)
	begin
		if (rst_i)
		begin
			started_q <= 1'b1;
			exp_hit_q <= 1'b0;
			for (int s = 0; s < `CACHE_NUM_SETS; s++)
			begin
				valid_s[s] <= 4'b0000;
				lru_s[s] <= 3'b000;
			end
		end
		else
		begin
			exp_hit_q <= access_i && (|req_match);
			exp_way_q <= req_way;
			exp_set_q <= req_set;
			exp_match_q <= req_match;
			exp_data_q <= line_s[req_set][req_way];
			if (exp_hit_q)
				lru_s[exp_set_q] <= mark_recent(lru_s[exp_set_q], exp_way_q);
			// a fill overrides both a hit update and an invalidate
			if (fill_i)
			begin
				lru_s[fill_set] <= mark_recent(lru_s[fill_set], victim);
				valid_s[fill_set][victim] <= 1'b1;
				tag_s[fill_set][victim] <= fill_tag;
				line_s[fill_set][victim] <= fill_data_i;
			end
			else if (invalidate_i)
			begin
				valid_s[invalidate_set_i][invalidate_way_i] <= 1'b0;
			end
		end
	end

	a_hit_flag: assert property (@(posedge clk) started_q |-> cache_hit_i == exp_hit_q)
	else
	begin
		$error("error cache_hit_o: expected %h got %h", $sampled(exp_hit_q),
			$sampled(cache_hit_i));
		error_count++;
	end

	a_hit_way: assert property (@(posedge clk) started_q && exp_hit_q |-> hit_way_i == exp_way_q)
	else
	begin
		$error("error hit_way_o: expected %h got %h", $sampled(exp_way_q), $sampled(hit_way_i));
		error_count++;
	end

	a_hit_data: assert property (@(posedge clk) started_q && exp_hit_q |-> data_i == exp_data_q)
	else
	begin
		$error("error data_o: expected %h got %h", $sampled(exp_data_q), $sampled(data_i));
		error_count++;
	end

	// a tag may sit in one way of a set only
	a_single_way: assert property (@(posedge clk)
		started_q && exp_hit_q |-> $onehot0(way_hit_i) && way_hit_i == exp_match_q)
	else
	begin
		$error("error way_hit: expected %h got %h", $sampled(exp_match_q),
			$sampled(way_hit_i));
		error_count++;
	end

	a_victim: assert property (@(posedge clk) started_q && !rst_i && fill_i |-> fill_way_i == victim)
	else
	begin
		$error("error fill_way: expected %h got %h", $sampled(victim), $sampled(fill_way_i));
		error_count++;
	end

endmodule

bind l1_cache l1_cache_assert u_check (
	.clk(clk),
	.rst_i(rst_i),
	.address_i(address_i),
	.access_i(access_i),
	.cache_hit_i(cache_hit_o),
	.hit_way_i(hit_way_o),
	.data_i(data_o),
	.fill_i(fill_i),
	.fill_address_i(fill_address_i),
	.fill_data_i(fill_data_i),
	.invalidate_i(invalidate_i),
	.invalidate_set_i(invalidate_set_i),
	.invalidate_way_i(invalidate_way_i),
	.fill_way_i(fill_way),
	.way_hit_i(u_tag_mem.way_hit)
);

// File: design/l1_cache.sv
`include "cache_settings.svh"

module l1_cache (
	input logic clk,
	input logic rst_i,
	input logic [31:0] address_i,
	input logic access_i,
	output logic cache_hit_o,
	output cache_pkg::way_t hit_way_o,
	output cache_pkg::line_t data_o,
	input logic fill_i,
	input logic [31:0] fill_address_i,
	input cache_pkg::line_t fill_data_i,
	input logic invalidate_i,
	input cache_pkg::set_t invalidate_set_i,
	input cache_pkg::way_t invalidate_way_i
);

	cache_pkg::set_t fill_set;
	cache_pkg::tag_t fill_tag;
	cache_pkg::way_t fill_way;
	cache_pkg::set_t hit_set;

	// refill address is split the same way as a lookup address
	assign fill_set = fill_address_i[`CACHE_OFFSET_BITS +: `CACHE_SET_BITS];
	assign fill_tag = fill_address_i[31 -: `CACHE_TAG_BITS];

	cache_tag_mem u_tag_mem (
		.clk(clk),
		.rst_i(rst_i),
		.address_i(address_i),
		.access_i(access_i),
		.fill_i(fill_i),
		.fill_set_i(fill_set),
		.fill_tag_i(fill_tag),
		.fill_way_i(fill_way),
		.invalidate_i(invalidate_i),
		.invalidate_set_i(invalidate_set_i),
		.invalidate_way_i(invalidate_way_i),
		.cache_hit_o(cache_hit_o),
		.hit_way_o(hit_way_o),
		.hit_set_o(hit_set)
	);

	cache_data_mem u_data_mem (
		.clk(clk),
		.address_i(address_i),
		.fill_i(fill_i),
		.fill_set_i(fill_set),
		.fill_way_i(fill_way),
		.fill_data_i(fill_data_i),
		.hit_way_i(hit_way_o),
		.data_o(data_o)
	);

	// the victim way is chosen here and fed back to both memories
	cache_lru u_lru (
		.clk(clk),
		.rst_i(rst_i),
		.hit_i(cache_hit_o),
		.hit_set_i(hit_set),
		.hit_way_i(hit_way_o),
		.fill_i(fill_i),
		.fill_set_i(fill_set),
		.fill_way_o(fill_way)
	);

endmodule

// File: design/cache_lru.sv
`include "cache_settings.svh"

module cache_lru (
	input logic clk,
	input logic rst_i,
	input logic hit_i,
	input cache_pkg::set_t hit_set_i,
	input cache_pkg::way_t hit_way_i,
	input logic fill_i,
	input cache_pkg::set_t fill_set_i,
	output cache_pkg::way_t fill_way_o
);

	cache_pkg::lru_t lru_q [`CACHE_NUM_SETS];
	cache_pkg::lru_t fill_lru;

	// mark a way as most recent by pointing every bit on its path away from it
	function automatic cache_pkg::lru_t touch(cache_pkg::lru_t cur, cache_pkg::way_t way);
		cache_pkg::lru_t nxt;
		nxt = cur;
		case (way)
			2'd0:
			begin
				nxt[0] = 1'b1;
				nxt[1] = 1'b1;
			end
			2'd1:
			begin
				nxt[0] = 1'b1;
				nxt[1] = 1'b0;
			end
			2'd2:
			begin
				nxt[0] = 1'b0;
				nxt[2] = 1'b1;
			end
			default:
			begin
				nxt[0] = 1'b0;
				nxt[2] = 1'b0;
			end
		endcase
		return nxt;
	endfunction

	assign fill_lru = lru_q[fill_set_i];

	// follow the tree: bit 0 picks the half, then bit 1 or bit 2 picks the way
	assign fill_way_o = fill_lru[0] ? {1'b1, fill_lru[2]} : {1'b0, fill_lru[1]};

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			for (int s = 0; s < `CACHE_NUM_SETS; s++)
			begin
				lru_q[s] <= 3'b000;
			end
		end
		else
		begin
			if (hit_i)
			begin
				lru_q[hit_set_i] <= touch(lru_q[hit_set_i], hit_way_i);
			end
			// placed last so a fill to the same set overrides the hit update
			if (fill_i)
			begin
				lru_q[fill_set_i] <= touch(fill_lru, fill_way_o);
			end
		end
	end

endmodule

// File: design/cache_data_mem.sv
`include "cache_settings.svh"

module cache_data_mem (
	input logic clk,
	input logic [31:0] address_i,
	input logic fill_i,
	input cache_pkg::set_t fill_set_i,
	input cache_pkg::way_t fill_way_i,
	input cache_pkg::line_t fill_data_i,
	input cache_pkg::way_t hit_way_i,
	output cache_pkg::line_t data_o
);

	cache_pkg::set_t read_set;
	cache_pkg::line_t line_rd [4];

	assign read_set = address_i[`CACHE_OFFSET_BITS +: `CACHE_SET_BITS];

	// every way is read on each lookup; the tag side decides which one is used
	for (genvar way = 0; way < 4; way++)
	begin : g_data_way
		sync_ram #(
			.payload_t(cache_pkg::line_t),
			.DEPTH(`CACHE_NUM_SETS)
		) u_line_ram (
			.clk(clk),
			.read_addr_i(read_set),
			.read_data_o(line_rd[way]),
			.write_en_i(fill_i && fill_way_i == cache_pkg::way_t'(way)),
			.write_addr_i(fill_set_i),
			.write_data_i(fill_data_i)
		);
	end

	// hit_way_i is valid in the result cycle, the same cycle the RAM outputs settle
	assign data_o = line_rd[hit_way_i];

endmodule

// File: design/cache_tag_mem.sv
`include "cache_settings.svh"

module cache_tag_mem (
	input logic clk,
	input logic rst_i,
	input logic [31:0] address_i,
	input logic access_i,
	input logic fill_i,
	input cache_pkg::set_t fill_set_i,
	input cache_pkg::tag_t fill_tag_i,
	input cache_pkg::way_t fill_way_i,
	input logic invalidate_i,
	input cache_pkg::set_t invalidate_set_i,
	input cache_pkg::way_t invalidate_way_i,
	output logic cache_hit_o,
	output cache_pkg::way_t hit_way_o,
	output cache_pkg::set_t hit_set_o
);

	cache_pkg::set_t req_set;
	cache_pkg::tag_t req_tag;

	// request fields held for the result cycle
	cache_pkg::set_t req_set_q;
	cache_pkg::tag_t req_tag_q;
	logic access_q;

	// one valid bit per way and set, kept in flops so reset can clear them
	logic [3:0] valid_q [`CACHE_NUM_SETS];
	logic [3:0] valid_rd_q;

	cache_pkg::tag_t tag_rd [4];
	logic [3:0] way_hit;

	assign req_set = address_i[`CACHE_OFFSET_BITS +: `CACHE_SET_BITS];
	assign req_tag = address_i[31 -: `CACHE_TAG_BITS];

	// the four tag arrays are looked up in parallel with the same set
	for (genvar way = 0; way < 4; way++)
	begin : g_tag_way
		sync_ram #(
			.payload_t(cache_pkg::tag_t),
			.DEPTH(`CACHE_NUM_SETS)
		) u_tag_ram (
			.clk(clk),
			.read_addr_i(req_set),
			.read_data_o(tag_rd[way]),
			.write_en_i(fill_i && fill_way_i == cache_pkg::way_t'(way)),
			.write_addr_i(fill_set_i),
			.write_data_i(fill_tag_i)
		);

		assign way_hit[way] = valid_rd_q[way] && tag_rd[way] == req_tag_q;
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			access_q <= 1'b0;
		end
		else
		begin
			access_q <= access_i;
		end
	end

	// valid bits are read alongside the tag RAMs, old value on a same-cycle write
	always_ff @(posedge clk)
	begin
		req_set_q <= req_set;
		req_tag_q <= req_tag;
		valid_rd_q <= valid_q[req_set];
	end

	// a fill beats an invalidate arriving in the same cycle
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			for (int s = 0; s < `CACHE_NUM_SETS; s++)
			begin
				valid_q[s] <= 4'b0000;
			end
		end
		else if (fill_i)
		begin
			valid_q[fill_set_i][fill_way_i] <= 1'b1;
		end
		else if (invalidate_i)
		begin
			valid_q[invalidate_set_i][invalidate_way_i] <= 1'b0;
		end
	end

	// lowest hitting way wins, way 3 is reported when nothing hits
	always_comb
	begin
		if (way_hit[0])
			hit_way_o = 2'd0;
		else if (way_hit[1])
			hit_way_o = 2'd1;
		else if (way_hit[2])
			hit_way_o = 2'd2;
		else
			hit_way_o = 2'd3;
	end

	assign cache_hit_o = access_q && (|way_hit);
	assign hit_set_o = req_set_q;

endmodule

// File: design/sync_ram.sv
module sync_ram #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 32
) (
	input logic clk,
	input logic [$clog2(DEPTH)-1:0] read_addr_i,
	output payload_t read_data_o,
	input logic write_en_i,
	input logic [$clog2(DEPTH)-1:0] write_addr_i,
	input payload_t write_data_i
);

	payload_t mem [DEPTH];

	// the read samples the array before this edge's write lands,
	// so a read and write to one address in the same cycle returns the old word
	always_ff @(posedge clk)
	begin
		read_data_o <= mem[read_addr_i];
		if (write_en_i)
		begin
			mem[write_addr_i] <= write_data_i;
		end
	end

endmodule

// File: design/cache_pkg.sv
`include "cache_settings.svh"

package cache_pkg;

	// index of one set in every way
	typedef logic [`CACHE_SET_BITS-1:0] set_t;

	// upper address bits kept per line
	typedef logic [`CACHE_TAG_BITS-1:0] tag_t;

	// one of the four ways
	typedef logic [1:0] way_t;

	// stored line payload
	typedef logic [`CACHE_LINE_BITS-1:0] line_t;

	// tree pseudo-LRU bits of one set
	// bit 0 picks the half, bit 1 picks within ways 0-1, bit 2 within ways 2-3
	typedef logic [2:0] lru_t;

endpackage

// File: design/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// geometry of the level-one cache lookup
// the way count is fixed at four and is not a setting

// number of sets in each way
`define CACHE_NUM_SETS 32

// set index width, log2 of the set count
`define CACHE_SET_BITS 5

// byte offset within a line, so the set index starts at bit 6
`define CACHE_OFFSET_BITS 6

// tag covers the address bits above the set index
`define CACHE_TAG_BITS 21

// width of one stored line
`define CACHE_LINE_BITS 64

`endif
